// File: include/rvx_config.svh
// RV64 sizes only; the ALU word-cut slices assume RVX_WORD_WD is 64
`ifndef RVX_CONFIG_SVH
`define RVX_CONFIG_SVH

// datapath
`define RVX_WORD_WD    64
`define RVX_INSTR_WD   32
`define RVX_REG_NR     32
`define RVX_REG_AW     5
`define RVX_ALU_OP_WD  5

// instruction fields
`define RVX_OPC_WD     7
`define RVX_FUNCT3_WD  3
`define RVX_FUNCT7_WD  7
`define RVX_IMM12_WD   12

`endif

// File: source/rvx_pkg.sv
// shared types for the execute slice; ALU keys must stay in step with the ALU mux table
`default_nettype none

`include "rvx_config.svh"

package rvx_pkg;

  // alu keys, upper-half multiplies sit at 25..27
  typedef enum logic [`RVX_ALU_OP_WD-1:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLT    = 5'd2,
    ALU_SLTU   = 5'd3,
    ALU_XOR    = 5'd4,
    ALU_AND    = 5'd5,
    ALU_OR     = 5'd6,
    ALU_SLL    = 5'd7,
    ALU_SRL    = 5'd8,
    ALU_SRA    = 5'd9,
    ALU_MUL    = 5'd10,
    ALU_DIV    = 5'd11,
    ALU_DIVU   = 5'd12,
    ALU_REM    = 5'd13,
    ALU_REMU   = 5'd14,
    ALU_COPY   = 5'd15,
    ALU_MULH   = 5'd25,
    ALU_MULHSU = 5'd26,
    ALU_MULHU  = 5'd27
  } alu_op_e;

  typedef struct packed {
    logic [`RVX_FUNCT7_WD-1:0] funct7;
    logic [`RVX_REG_AW-1:0]    rs2;
    logic [`RVX_REG_AW-1:0]    rs1;
    logic [`RVX_FUNCT3_WD-1:0] funct3;
    logic [`RVX_REG_AW-1:0]    rd;
    logic [`RVX_OPC_WD-1:0]    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [`RVX_IMM12_WD-1:0]  imm12;
    logic [`RVX_REG_AW-1:0]    rs1;
    logic [`RVX_FUNCT3_WD-1:0] funct3;
    logic [`RVX_REG_AW-1:0]    rd;
    logic [`RVX_OPC_WD-1:0]    opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // major opcodes handled by the slice
  localparam logic [`RVX_OPC_WD-1:0] OPC_OP        = 7'b0110011;
  localparam logic [`RVX_OPC_WD-1:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [`RVX_OPC_WD-1:0] OPC_OP_32     = 7'b0111011;
  localparam logic [`RVX_OPC_WD-1:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [`RVX_OPC_WD-1:0] OPC_LUI       = 7'b0110111;

endpackage

`default_nettype wire

// File: source/rvx_exec_if.sv
// decoded control for one instruction; valid only in the strobe cycle
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

interface rvx_exec_if;
  import rvx_pkg::*;

  logic [`RVX_REG_AW-1:0]  rs1;
  logic [`RVX_REG_AW-1:0]  rs2;
  logic [`RVX_REG_AW-1:0]  rd;
  alu_op_e                 alu_op;
  logic                    word_cut;
  logic                    use_imm;
  logic [`RVX_WORD_WD-1:0] imm;
  logic                    wen;

  modport dec (
    output rs1, rs2, rd, alu_op, word_cut, use_imm, imm, wen
  );

  modport rf (
    input rs1, rs2, rd, wen
  );

  modport alu (
    input alu_op, word_cut
  );

endinterface

`default_nettype wire

// File: source/rvx_mux_key.sv
// keys must be unique in i_lut; an unmatched key gives zero
`timescale 1ns/1ps
`default_nettype none

module rvx_mux_key #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  wire  [KEY_LEN-1:0]                   i_key,
  input  wire  [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] i_lut,
  output logic [DATA_LEN-1:0]                  o_out
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  // each pair is {key, data}, data in the low bits
  always_comb begin
    o_out = '0;
    for (int n = 0; n < NR_KEY; n++) begin
      if (i_lut[n*PAIR_LEN+DATA_LEN +: KEY_LEN] == i_key) begin
        o_out = i_lut[n*PAIR_LEN +: DATA_LEN];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rvx_decoder.sv
// OP, OP-IMM, OP-32, OP-IMM-32 and LUI only; anything else is flagged illegal
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_decoder (
  input  wire             i_instr_valid,
  input  wire  rvx_pkg::instr_u i_instr,
  rvx_exec_if.dec         dec,
  output logic            o_illegal_now
);
  import rvx_pkg::*;

  localparam int W = `RVX_WORD_WD;
  localparam logic [`RVX_FUNCT7_WD-1:0] F7_BASE   = 7'b0000000;
  localparam logic [`RVX_FUNCT7_WD-1:0] F7_ALT    = 7'b0100000;
  localparam logic [`RVX_FUNCT7_WD-1:0] F7_MULDIV = 7'b0000001;

  logic [`RVX_OPC_WD-1:0]    opcode;
  logic [`RVX_FUNCT3_WD-1:0] funct3;
  logic [`RVX_FUNCT7_WD-1:0] funct7;
  logic [`RVX_IMM12_WD-1:0]  imm12;
  logic [19:0]               imm20;
  alu_op_e                   op_sel;
  logic                      legal;
  logic                      word_cut;
  logic                      use_imm;
  logic [W-1:0]              imm;

  // funct3 map shared by register and immediate forms
  function automatic alu_op_e base_op(input logic [`RVX_FUNCT3_WD-1:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e muldiv_op(input logic [`RVX_FUNCT3_WD-1:0] f3);
    case (f3)
      3'd0:    return ALU_MUL;
      3'd1:    return ALU_MULH;
      3'd2:    return ALU_MULHSU;
      3'd3:    return ALU_MULHU;
      3'd4:    return ALU_DIV;
      3'd5:    return ALU_DIVU;
      3'd6:    return ALU_REM;
      default: return ALU_REMU;
    endcase
  endfunction

  // r view for funct7, i view for the immediate
  assign opcode = i_instr.r.opcode;
  assign funct7 = i_instr.r.funct7;
  assign funct3 = i_instr.i.funct3;
  assign imm12  = i_instr.i.imm12;
  assign imm20  = {i_instr.i.imm12, i_instr.i.rs1, i_instr.i.funct3};

  always_comb begin
    op_sel   = ALU_ADD;
    legal    = 1'b1;
    word_cut = 1'b0;
    use_imm  = 1'b0;
    imm      = '0;
    case (opcode)
      OPC_OP, OPC_OP_32: begin
        word_cut = (opcode == OPC_OP_32);
        case (funct7)
          F7_BASE: begin
            op_sel = base_op(funct3);
            legal  = !word_cut || (funct3 inside {3'd0, 3'd1, 3'd5});
          end
          F7_ALT: begin
            op_sel = (funct3 == 3'd5) ? ALU_SRA : ALU_SUB;
            legal  = (funct3 == 3'd0) || (funct3 == 3'd5);
          end
          F7_MULDIV: begin
            op_sel = muldiv_op(funct3);
            legal  = !word_cut || (funct3 == 3'd0) || funct3[2];
          end
          default: legal = 1'b0;
        endcase
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        word_cut = (opcode == OPC_OP_IMM_32);
        use_imm  = 1'b1;
        imm      = {{(W-`RVX_IMM12_WD){imm12[`RVX_IMM12_WD-1]}}, imm12};
        op_sel   = base_op(funct3);
        case (funct3)
          3'd0: legal = 1'b1;
          3'd1: legal = word_cut ? (funct7 == F7_BASE) : (funct7[6:1] == 6'b000000);
          3'd5: begin
            // bit 30 picks srai over srli
            op_sel = funct7[5] ? ALU_SRA : ALU_SRL;
            legal  = word_cut ? (funct7 inside {F7_BASE, F7_ALT})
                              : (funct7[6:1] inside {6'b000000, 6'b010000});
          end
          default: legal = !word_cut;
        endcase
      end
      OPC_LUI: begin
        op_sel  = ALU_COPY;
        use_imm = 1'b1;
        imm     = {{(W-32){imm20[19]}}, imm20, 12'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  assign dec.rs1      = i_instr.r.rs1;
  assign dec.rs2      = i_instr.r.rs2;
  assign dec.rd       = i_instr.r.rd;
  assign dec.alu_op   = op_sel;
  assign dec.word_cut = word_cut;
  assign dec.use_imm  = use_imm;
  assign dec.imm      = imm;
  assign dec.wen      = i_instr_valid & legal;
  assign o_illegal_now = i_instr_valid & ~legal;

endmodule

`default_nettype wire

// File: source/rvx_regfile.sv
// two async read ports, one write port; the write lands on the edge after the strobe
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_regfile (
  input  wire                     i_clk,
  input  wire                     i_rst,
  rvx_exec_if.rf                  rf,
  input  wire  [`RVX_WORD_WD-1:0] i_wdata,
  output logic [`RVX_WORD_WD-1:0] o_rs1_data,
  output logic [`RVX_WORD_WD-1:0] o_rs2_data
);

  localparam int W = `RVX_WORD_WD;

  logic [W-1:0] regs [`RVX_REG_NR];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int n = 0; n < `RVX_REG_NR; n++) begin
        regs[n] <= '0;
      end
    end else if (rf.wen && (rf.rd != '0)) begin
      regs[rf.rd] <= i_wdata;
    end
  end

  // x0 reads as zero whatever sits in slot 0
  assign o_rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
  assign o_rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

`default_nettype wire

// File: source/rvx_alu.sv
// purely combinational RV64IM unit; word-cut forms assume a 64-bit word
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_alu (
  input  wire  [`RVX_WORD_WD-1:0] i_src_a,
  input  wire  [`RVX_WORD_WD-1:0] i_src_b,
  rvx_exec_if.alu                 alu,
  output logic [`RVX_WORD_WD-1:0] o_alu_result
);
  import rvx_pkg::*;

  localparam int W      = `RVX_WORD_WD;
  localparam int HW     = W / 2;
  localparam int SHW    = $clog2(W);
  localparam int NR_OPS = 19;

  logic [SHW-1:0]      shamt;
  logic [W-1:0]        add_res;
  logic [W-1:0]        sub_res;
  logic [W-1:0]        slt_res;
  logic [W-1:0]        sltu_res;
  logic [W-1:0]        sll_res;
  logic [W-1:0]        srl_src;
  logic [W-1:0]        srl_res;
  logic [HW-1:0]       sra_word;
  logic [W-1:0]        sra_full;
  logic [W-1:0]        sra_res;
  logic [2*W-1:0]      prod_ss;
  logic [2*W-1:0]      prod_su;
  logic [2*W-1:0]      prod_uu;
  logic [W-1:0]        div_a_s;
  logic [W-1:0]        div_b_s;
  logic [W-1:0]        div_a_u;
  logic [W-1:0]        div_b_u;
  logic signed [W-1:0] quot_s;
  logic signed [W-1:0] rmd_s;
  logic [W-1:0]        quot_u;
  logic [W-1:0]        rmd_u;
  logic                div_zero;
  logic                div_ovf;
  logic [W-1:0]        div_res;
  logic [W-1:0]        divu_res;
  logic [W-1:0]        rem_res;
  logic [W-1:0]        remu_res;
  logic [W-1:0]        mux_res;

  assign add_res  = i_src_a + i_src_b;
  assign sub_res  = i_src_a - i_src_b;
  assign slt_res  = {{(W-1){1'b0}}, $signed(i_src_a) < $signed(i_src_b)};
  assign sltu_res = {{(W-1){1'b0}}, i_src_a < i_src_b};

  // word forms shift by 0..31 only
  assign shamt    = alu.word_cut ? {1'b0, i_src_b[SHW-2:0]} : i_src_b[SHW-1:0];
  assign sll_res  = i_src_a << shamt;
  assign srl_src  = alu.word_cut ? {{HW{1'b0}}, i_src_a[HW-1:0]} : i_src_a;
  assign srl_res  = srl_src >> shamt;
  assign sra_word = $signed(i_src_a[HW-1:0]) >>> shamt;
  assign sra_full = $signed(i_src_a) >>> shamt;
  assign sra_res  = alu.word_cut ? {{HW{sra_word[HW-1]}}, sra_word} : sra_full;

  // operands widened first, so the upper half is exact for each sign mix
  assign prod_ss = {{W{i_src_a[W-1]}}, i_src_a} * {{W{i_src_b[W-1]}}, i_src_b};
  assign prod_su = {{W{i_src_a[W-1]}}, i_src_a} * {{W{1'b0}}, i_src_b};
  assign prod_uu = {{W{1'b0}}, i_src_a} * {{W{1'b0}}, i_src_b};

  assign div_a_s = alu.word_cut ? {{HW{i_src_a[HW-1]}}, i_src_a[HW-1:0]} : i_src_a;
  assign div_b_s = alu.word_cut ? {{HW{i_src_b[HW-1]}}, i_src_b[HW-1:0]} : i_src_b;
  assign div_a_u = alu.word_cut ? {{HW{1'b0}}, i_src_a[HW-1:0]} : i_src_a;
  assign div_b_u = alu.word_cut ? {{HW{1'b0}}, i_src_b[HW-1:0]} : i_src_b;

  assign quot_s = $signed(div_a_s) / $signed(div_b_s);
  assign rmd_s  = $signed(div_a_s) % $signed(div_b_s);
  assign quot_u = div_a_u / div_b_u;
  assign rmd_u  = div_a_u % div_b_u;

  // the W overflow case never trips this, its plain quotient is already right
  assign div_zero = (div_b_u == '0);
  assign div_ovf  = (div_a_s == {1'b1, {(W-1){1'b0}}}) && (div_b_s == '1);

  assign div_res  = div_zero ? '1 : (div_ovf ? div_a_s : quot_s);
  assign rem_res  = div_zero ? div_a_s : (div_ovf ? '0 : rmd_s);
  assign divu_res = div_zero ? '1 : quot_u;
  assign remu_res = div_zero ? div_a_u : rmd_u;

  rvx_mux_key #(
    .NR_KEY   (NR_OPS),
    .KEY_LEN  (`RVX_ALU_OP_WD),
    .DATA_LEN (W)
  ) u_mux_key (
    .i_key (alu.alu_op),
    .i_lut ({
      ALU_COPY,   i_src_b,
      ALU_ADD,    add_res,
      ALU_SUB,    sub_res,
      ALU_SLT,    slt_res,
      ALU_SLTU,   sltu_res,
      ALU_XOR,    i_src_a ^ i_src_b,
      ALU_AND,    i_src_a & i_src_b,
      ALU_OR,     i_src_a | i_src_b,
      ALU_SLL,    sll_res,
      ALU_SRL,    srl_res,
      ALU_SRA,    sra_res,
      ALU_MUL,    prod_uu[W-1:0],
      ALU_MULH,   prod_ss[2*W-1:W],
      ALU_MULHSU, prod_su[2*W-1:W],
      ALU_MULHU,  prod_uu[2*W-1:W],
      ALU_DIV,    div_res,
      ALU_DIVU,   divu_res,
      ALU_REM,    rem_res,
      ALU_REMU,   remu_res
    }),
    .o_out (mux_res)
  );

  // word forms return the low half sign-extended
  assign o_alu_result = alu.word_cut ? {{HW{mux_res[HW-1]}}, mux_res[HW-1:0]} : mux_res;

endmodule

`default_nettype wire

// File: source/rvx_exec_top.sv
// one strobe per cycle at most, no back-pressure; results appear one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_exec_top (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_instr_valid,
  input  wire  [`RVX_INSTR_WD-1:0] i_instr,
  output logic                     o_wb_valid,
  output logic [`RVX_REG_AW-1:0]   o_wb_rd,
  output logic [`RVX_WORD_WD-1:0]  o_wb_data,
  output logic                     o_illegal
);
  import rvx_pkg::*;

  localparam int W = `RVX_WORD_WD;

  logic         illegal_now;
  logic [W-1:0] rs1_data;
  logic [W-1:0] rs2_data;
  logic [W-1:0] src_a;
  logic [W-1:0] src_b;
  logic [W-1:0] alu_result;

  rvx_exec_if u_exec_if ();

  rvx_decoder u_decoder (
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .dec           (u_exec_if.dec),
    .o_illegal_now (illegal_now)
  );

  rvx_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .rf         (u_exec_if.rf),
    .i_wdata    (alu_result),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // lui carries no rs1, its upper bits are immediate
  assign src_a = (u_exec_if.alu_op == ALU_COPY) ? '0 : rs1_data;
  assign src_b = u_exec_if.use_imm ? u_exec_if.imm : rs2_data;

  rvx_alu u_alu (
    .i_src_a      (src_a),
    .i_src_b      (src_b),
    .alu          (u_exec_if.alu),
    .o_alu_result (alu_result)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_valid <= 1'b0;
      o_illegal  <= 1'b0;
      o_wb_rd    <= '0;
      o_wb_data  <= '0;
    end else begin
      o_wb_valid <= u_exec_if.wen;
      o_illegal  <= illegal_now;
      if (u_exec_if.wen) begin
        o_wb_rd   <= u_exec_if.rd;
        o_wb_data <= alu_result;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/rvx_exec_tb.sv
// fixed seed 32'h2941; the reference model assumes a 64-bit word and one strobe per cycle
`timescale 1ns/1ps
`default_nettype none

`include "rvx_config.svh"

module rvx_exec_tb;
  import rvx_pkg::*;

  localparam int W            = `RVX_WORD_WD;
  localparam int W2           = 2 * W;
  localparam int RESET_CYCLES = 16;
  localparam int N_RAND       = 200;
  // cycle budget of each test in run order including its drain
  localparam int TEST_CYCLES  = 10 + 70 + (N_RAND + 2) + 22 + 10 + 12;
  localparam int TIMEOUT      = 2 * TEST_CYCLES + RESET_CYCLES;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   instr_valid;
  logic [31:0]            instr;
  logic                   wb_valid;
  logic [`RVX_REG_AW-1:0] wb_rd;
  logic [W-1:0]           wb_data;
  logic                   illegal;

  // expectation for the strobe in flight, then delayed to line up with the outputs
  logic                   exp_valid;
  logic                   exp_illegal;
  logic [`RVX_REG_AW-1:0] exp_rd;
  logic [W-1:0]           exp_data;
  logic                   exp_valid_q;
  logic                   exp_illegal_q;
  logic [`RVX_REG_AW-1:0] exp_rd_q;
  logic [W-1:0]           exp_data_q;

  logic [W-1:0] model_regs [`RVX_REG_NR];
  int           error_count  = 0;
  int           tests_run    = 0;
  int           tests_passed = 0;
  int           cycles       = 0;

  alu_op_e full_ops [18] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_AND,
                             ALU_OR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH,
                             ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  alu_op_e word_ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL,
                             ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

  rvx_exec_top u_rvx_exec_top (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_instr_valid (instr_valid),
    .i_instr       (instr),
    .o_wb_valid    (wb_valid),
    .o_wb_rd       (wb_rd),
    .o_wb_data     (wb_data),
    .o_illegal     (illegal)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    exp_valid_q   <= exp_valid;
    exp_illegal_q <= exp_illegal;
    exp_rd_q      <= exp_rd;
    exp_data_q    <= exp_data;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  a_wb_valid: assert property (@(posedge clk) disable iff (rst) wb_valid == exp_valid_q)
    else report_value("o_wb_valid", W'($sampled(wb_valid)), W'($sampled(exp_valid_q)));
  a_illegal: assert property (@(posedge clk) disable iff (rst) illegal == exp_illegal_q)
    else report_value("o_illegal", W'($sampled(illegal)), W'($sampled(exp_illegal_q)));
  a_wb_rd: assert property (@(posedge clk) disable iff (rst) !exp_valid_q || wb_rd == exp_rd_q)
    else report_value("o_wb_rd", W'($sampled(wb_rd)), W'($sampled(exp_rd_q)));
  a_wb_data: assert property (@(posedge clk) disable iff (rst)
                              !exp_valid_q || wb_data == exp_data_q)
    else report_value("o_wb_data", $sampled(wb_data), $sampled(exp_data_q));

  task automatic report_value(input string name, input logic [W-1:0] got,
                              input logic [W-1:0] want);
    error_count++;
    $display("[ERROR] %s: got %h expected %h", name, got, want);
  endtask

  // W forms are computed on 32-bit values and then sign-extended
  function automatic logic [W-1:0] model_alu(input alu_op_e op, input logic word,
                                             input logic [W-1:0] a, input logic [W-1:0] b);
    logic [2*W-1:0] wide;
    logic [W-1:0]   r;
    logic [31:0]    wa;
    logic [31:0]    wb;
    logic [31:0]    wr;
    wa = a[31:0];
    wb = b[31:0];
    if (word) begin
      case (op)
        ALU_ADD: wr = wa + wb;
        ALU_SUB: wr = wa - wb;
        ALU_SLL: wr = wa << wb[4:0];
        ALU_SRL: wr = wa >> wb[4:0];
        ALU_SRA: wr = $signed(wa) >>> wb[4:0];
        ALU_MUL: wr = wa * wb;
        ALU_DIV:
          if (wb == '0) wr = '1;
          else if (wa == 32'h8000_0000 && wb == '1) wr = wa;
          else wr = $signed(wa) / $signed(wb);
        ALU_DIVU: wr = (wb == '0) ? '1 : wa / wb;
        ALU_REM:
          if (wb == '0) wr = wa;
          else if (wa == 32'h8000_0000 && wb == '1) wr = '0;
          else wr = $signed(wa) % $signed(wb);
        ALU_REMU: wr = (wb == '0) ? wa : wa % wb;
        default: wr = '0;
      endcase
      return {{(W-32){wr[31]}}, wr};
    end
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
      ALU_XOR:  r = a ^ b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_SLL:  r = a << b[5:0];
      ALU_SRL:  r = a >> b[5:0];
      ALU_SRA:  r = $signed(a) >>> b[5:0];
      ALU_MUL:  r = a * b;
      ALU_MULH, ALU_MULHSU, ALU_MULHU: begin
        // signed upper halves correct the unsigned one for each negative operand
        wide = W2'(a) * W2'(b);
        r    = wide[2*W-1:W];
        if (op != ALU_MULHU && a[W-1]) r = r - b;
        if (op == ALU_MULH && b[W-1]) r = r - a;
      end
      ALU_DIV:
        if (b == '0) r = '1;
        else if (a == {1'b1, {(W-1){1'b0}}} && b == '1) r = a;
        else r = $signed(a) / $signed(b);
      ALU_DIVU: r = (b == '0) ? '1 : a / b;
      ALU_REM:
        if (b == '0) r = a;
        else if (a == {1'b1, {(W-1){1'b0}}} && b == '1) r = '0;
        else r = $signed(a) % $signed(b);
      ALU_REMU: r = (b == '0) ? a : a % b;
      ALU_COPY: r = b;
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [2:0] funct3_of(input alu_op_e op);
    case (op)
      ALU_ADD, ALU_SUB, ALU_MUL:    return 3'd0;
      ALU_SLL, ALU_MULH:            return 3'd1;
      ALU_SLT, ALU_MULHSU:          return 3'd2;
      ALU_SLTU, ALU_MULHU:          return 3'd3;
      ALU_XOR, ALU_DIV:             return 3'd4;
      ALU_SRL, ALU_SRA, ALU_DIVU:   return 3'd5;
      ALU_OR, ALU_REM:              return 3'd6;
      default:                      return 3'd7;
    endcase
  endfunction

  function automatic logic [6:0] funct7_of(input alu_op_e op);
    if (op == ALU_SUB || op == ALU_SRA) return 7'b0100000;
    if (op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, ALU_DIV, ALU_DIVU, ALU_REM,
                   ALU_REMU}) return 7'b0000001;
    return 7'b0000000;
  endfunction

  function automatic instr_u encode_r(input alu_op_e op, input logic word, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
    instr_u u;
    u.r.opcode = word ? OPC_OP_32 : OPC_OP;
    u.r.funct7 = funct7_of(op);
    u.r.funct3 = funct3_of(op);
    u.r.rd     = rd;
    u.r.rs1    = rs1;
    u.r.rs2    = rs2;
    return u;
  endfunction

  function automatic instr_u encode_i(input alu_op_e op, input logic word, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [11:0] imm12);
    instr_u u;
    u.i.opcode = word ? OPC_OP_IMM_32 : OPC_OP_IMM;
    u.i.imm12  = imm12;
    u.i.funct3 = funct3_of(op);
    u.i.rd     = rd;
    u.i.rs1    = rs1;
    // srai and sraiw carry bit 30
    if (op == ALU_SRA) u.i.imm12[10] = 1'b1;
    return u;
  endfunction

  // one strobe from the current falling edge to the next
  task automatic send(input logic [31:0] word_in, input logic ok, input logic [4:0] rd,
                      input logic [W-1:0] data);
    instr_valid = 1'b1;
    instr       = word_in;
    exp_valid   = ok;
    exp_illegal = !ok;
    exp_rd      = rd;
    exp_data    = data;
    if (ok && rd != '0) model_regs[rd] = data;
    @(negedge clk);
    instr_valid = 1'b0;
    exp_valid   = 1'b0;
    exp_illegal = 1'b0;
  endtask

  task automatic run_reg_op(input alu_op_e op, input logic word, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
    send(encode_r(op, word, rd, rs1, rs2), 1'b1, rd,
         model_alu(op, word, model_regs[rs1], model_regs[rs2]));
  endtask

  task automatic run_imm_op(input alu_op_e op, input logic word, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [11:0] imm12);
    send(encode_i(op, word, rd, rs1, imm12), 1'b1, rd,
         model_alu(op, word, model_regs[rs1], {{(W-12){imm12[11]}}, imm12}));
  endtask

  task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm20);
    send({imm20, rd, OPC_LUI}, 1'b1, rd, {{(W-32){imm20[19]}}, imm20, 12'h000});
  endtask

  task automatic send_illegal(input logic [31:0] word_in);
    send(word_in, 1'b0, 5'd0, '0);
  endtask

  task automatic close_test(input string name, input int errs_before);
    repeat (2) @(negedge clk);
    tests_run++;
    if (error_count == errs_before) begin
      tests_passed++;
      $display("test %s ok", name);
    end else begin
      $display("test %s failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic check_quiet();
    int errs;
    errs = error_count;
    repeat (8) begin
      assert (wb_rd == '0)
        else report_value("o_wb_rd", W'(wb_rd), '0);
      assert (wb_data == '0)
        else report_value("o_wb_data", wb_data, '0);
      @(negedge clk);
    end
    close_test("quiet_reset", errs);
  endtask

  task automatic setup_regs();
    int errs;
    logic [4:0] rd;
    errs = error_count;
    for (int n = 1; n <= 8; n++) begin
      rd = 5'(n);
      load_upper(rd, 20'($urandom));
      run_imm_op(ALU_ADD, 1'b0, rd, rd, 12'($urandom));
      run_imm_op(ALU_SLL, 1'b0, rd, rd, 12'd20);
      run_imm_op(ALU_XOR, 1'b0, rd, rd, 12'($urandom));
      run_imm_op(ALU_SLL, 1'b0, rd, rd, 12'd12);
      run_imm_op(ALU_XOR, 1'b0, rd, rd, 12'($urandom));
    end
    run_imm_op(ALU_ADD, 1'b1, 5'd9, 5'd1, 12'h7ff);
    run_imm_op(ALU_SRA, 1'b1, 5'd9, 5'd9, 12'd3);
    run_imm_op(ALU_SRA, 1'b0, 5'd9, 5'd9, 12'd17);
    run_imm_op(ALU_SRL, 1'b1, 5'd9, 5'd9, 12'd5);
    run_imm_op(ALU_SLT, 1'b0, 5'd20, 5'd2, 12'h800);
    run_imm_op(ALU_SLTU, 1'b0, 5'd20, 5'd3, 12'hfff);
    // x10 most negative, x11 minus one, x12 most negative word, x13 zero
    run_imm_op(ALU_ADD, 1'b0, 5'd10, 5'd0, 12'd1);
    run_imm_op(ALU_SLL, 1'b0, 5'd10, 5'd10, 12'd63);
    run_imm_op(ALU_ADD, 1'b0, 5'd11, 5'd0, 12'hfff);
    load_upper(5'd12, 20'h80000);
    run_imm_op(ALU_AND, 1'b0, 5'd13, 5'd4, 12'h000);
    close_test("setup_regs", errs);
  endtask

  task automatic random_ops();
    int errs;
    logic    word;
    alu_op_e op;
    errs = error_count;
    for (int n = 0; n < N_RAND; n++) begin
      word = 1'($urandom_range(1));
      if (word) op = word_ops[4'($urandom_range(9))];
      else op = full_ops[5'($urandom_range(17))];
      // destinations stay clear of the corner operands in x10..x13
      run_reg_op(op, word, 5'($urandom_range(20, 14)), 5'($urandom_range(20)),
                 5'($urandom_range(20)));
    end
    close_test("random_ops", errs);
  endtask

  task automatic div_corners();
    int errs;
    alu_op_e ops [4];
    errs = error_count;
    ops = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    foreach (ops[k]) begin
      run_reg_op(ops[k], 1'b0, 5'd14, 5'd3, 5'd13);
      run_reg_op(ops[k], 1'b1, 5'd15, 5'd3, 5'd13);
      // low word of x10 is zero
      run_reg_op(ops[k], 1'b1, 5'd16, 5'd1, 5'd10);
      run_reg_op(ops[k], 1'b0, 5'd17, 5'd10, 5'd11);
      run_reg_op(ops[k], 1'b1, 5'd18, 5'd12, 5'd11);
    end
    close_test("div_corners", errs);
  endtask

  task automatic x0_and_deps();
    int errs;
    errs = error_count;
    run_reg_op(ALU_ADD, 1'b0, 5'd0, 5'd1, 5'd2);
    run_imm_op(ALU_ADD, 1'b0, 5'd0, 5'd3, 12'h123);
    run_reg_op(ALU_OR, 1'b0, 5'd14, 5'd0, 5'd0);
    run_imm_op(ALU_ADD, 1'b0, 5'd15, 5'd1, 12'd5);
    run_imm_op(ALU_ADD, 1'b0, 5'd15, 5'd15, 12'd7);
    run_reg_op(ALU_ADD, 1'b0, 5'd16, 5'd15, 5'd15);
    run_reg_op(ALU_SUB, 1'b1, 5'd17, 5'd16, 5'd1);
    close_test("x0_and_deps", errs);
  endtask

  task automatic illegal_encodings();
    int errs;
    instr_u u;
    errs = error_count;
    send_illegal({12'h000, 5'd1, 3'd3, 5'd8, 7'b0000011});
    u = encode_r(ALU_ADD, 1'b0, 5'd8, 5'd1, 5'd2);
    u.r.funct7 = 7'b0000010;
    send_illegal(u);
    send_illegal(encode_r(ALU_SLT, 1'b1, 5'd8, 5'd1, 5'd2));
    send_illegal(encode_r(ALU_MULH, 1'b1, 5'd8, 5'd1, 5'd2));
    u = encode_i(ALU_SRA, 1'b1, 5'd8, 5'd1, 12'd3);
    u.r.funct7[0] = 1'b1;
    send_illegal(u);
    send_illegal(encode_i(ALU_XOR, 1'b1, 5'd8, 5'd1, 12'h005));
    send_illegal(encode_i(ALU_SLL, 1'b1, 5'd8, 5'd1, 12'd33));
    // x8 must still hold its old value
    run_imm_op(ALU_ADD, 1'b0, 5'd14, 5'd8, 12'h000);
    close_test("illegal_encoding", errs);
  endtask

  initial begin
    void'($urandom(32'h2941));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_illegal = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    foreach (model_regs[n]) model_regs[n] = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_quiet();
    setup_regs();
    random_ops();
    div_corners();
    x0_and_deps();
    illegal_encodings();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rvx_exec.f
+incdir+include
source/rvx_pkg.sv
source/rvx_exec_if.sv
source/rvx_mux_key.sv
source/rvx_decoder.sv
source/rvx_regfile.sv
source/rvx_alu.sv
source/rvx_exec_top.sv
tests/rvx_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module rvx_exec_tb -f rvx_exec.f -o rvx_exec_sim \
  && ./obj_dir/rvx_exec_sim > sim.log 2>&1 \
  || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "failure found in sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
